/* logic/tracker_pkg.sv */
package tracker_pkg;

    // coordinate and accumulator widths
    localparam int COORD_W = 12;     // pixel x / y
    localparam int COUNT_W = 20;     // matched pixels per frame
    localparam int SUM_W   = 32;     // coordinate sums, also divider width
    localparam int POS_W   = 12;     // mapped output positions

    // RGB565 channel thresholds
    localparam logic [4:0] RED_MIN          = 5'd20;
    localparam logic [5:0] GREEN_MAX        = 6'd24;
    localparam logic [4:0] BLUE_MIN         = 5'd20;
    localparam logic [4:0] RED_MAX_FOR_BLUE = 5'd12;  // hand needs little red

    // output shaping
    localparam int POS_BIAS  = 1800;  // keeps outputs clear of zero
    localparam int HEAD_LIFT = 75;    // head drawn above the hand

    // frames to let exposure settle before the origin is taken
    localparam int CAL_FRAMES = 3;
    localparam int CAL_W      = $clog2(CAL_FRAMES + 1);

endpackage

/* logic/pixel_capture.sv */
`timescale 1ns/100ps

module pixel_capture import tracker_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic [7:0]         cam_data,
    input  logic               cam_pclk,
    input  logic               cam_href,
    input  logic               cam_vsync,
    output logic               cam_xclk,
    output logic               cam_pwdn,
    output logic               pix_valid,
    output logic [15:0]        pix_rgb,
    output logic [COORD_W-1:0] pix_x,
    output logic [COORD_W-1:0] pix_y,
    output logic               frame_end
);

    logic [7:0]         data_meta, data_sync;        // byte rides the same two stages
    logic [2:0]         ctl_meta, ctl_sync, ctl_prev; // {vsync, href, pclk}
    logic               pclk_rise, href_fall, vsync_rise;
    logic               take_byte;
    logic               byte_phase;                   // high while first byte is held
    logic [7:0]         hi_byte;
    logic [COORD_W-1:0] x_cnt, y_cnt;

    assign cam_pwdn = 1'b0;  // camera stays powered

    assign pclk_rise  = ctl_sync[0] & ~ctl_prev[0];
    assign href_fall  = ~ctl_sync[1] & ctl_prev[1];  // end of a line
    assign vsync_rise = ctl_sync[2] & ~ctl_prev[2];
    assign take_byte  = pclk_rise & ctl_sync[1];     // only bytes inside href

    // camera master clock, half the system rate
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cam_xclk <= 1'b0;
        end else begin
            cam_xclk <= ~cam_xclk;
        end
    end

    // two-flop sync of the control pins, plus one for edges
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ctl_meta <= '0;
            ctl_sync <= '0;
            ctl_prev <= '0;
        end else begin
            ctl_meta <= {cam_vsync, cam_href, cam_pclk};
            ctl_sync <= ctl_meta;
            ctl_prev <= ctl_sync;
        end
    end

    always_ff @(posedge clk_in) begin
        data_meta <= cam_data;
        data_sync <= data_meta;  // lines up with ctl_sync
    end

    // byte pairing and coordinate counters
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pix_valid  <= 1'b0;
            frame_end  <= 1'b0;
            byte_phase <= 1'b0;
            x_cnt      <= '0;
            y_cnt      <= '0;
        end else begin
            pix_valid <= 1'b0;
            frame_end <= vsync_rise;
            if (vsync_rise) begin
                x_cnt      <= '0;
                y_cnt      <= '0;
                byte_phase <= 1'b0;
            end else if (href_fall) begin
                x_cnt      <= '0;
                y_cnt      <= y_cnt + 1'b1;  // next line
                byte_phase <= 1'b0;
            end else if (take_byte) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin
                    pix_valid <= 1'b1;          // second byte completes the pixel
                    x_cnt     <= x_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (take_byte) begin
            if (!byte_phase) begin
                hi_byte <= data_sync;  // r5 g3
            end else begin
                pix_rgb <= {hi_byte, data_sync};
                pix_x   <= x_cnt;
                pix_y   <= y_cnt;
            end
        end
    end

endmodule

/* logic/color_classifier.sv */
`timescale 1ns/100ps

module color_classifier import tracker_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               pix_valid,
    input  logic [15:0]        pix_rgb,
    input  logic [COORD_W-1:0] pix_x,
    input  logic [COORD_W-1:0] pix_y,
    input  logic               frame_end,
    output logic               cls_valid,
    output logic [COORD_W-1:0] cls_x,
    output logic [COORD_W-1:0] cls_y,
    output logic               is_head,
    output logic               is_hand,
    output logic               cls_frame_end
);

    logic [4:0] red, blue;
    logic [5:0] green;
    logic       head_hit, hand_hit;

    // RGB565 split
    assign red   = pix_rgb[15:11];
    assign green = pix_rgb[10:5];
    assign blue  = pix_rgb[4:0];

    // red marker, head
    assign head_hit = (red >= RED_MIN) && (green <= GREEN_MAX) && (blue < BLUE_MIN);
    // blue marker, hand
    assign hand_hit = (blue >= BLUE_MIN) && (green <= GREEN_MAX) && (red < RED_MAX_FOR_BLUE);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cls_valid     <= 1'b0;
            is_head       <= 1'b0;
            is_hand       <= 1'b0;
            cls_frame_end <= 1'b0;
        end else begin
            cls_valid     <= pix_valid;
            is_head       <= pix_valid & head_hit;
            is_hand       <= pix_valid & hand_hit;
            cls_frame_end <= frame_end;  // same delay as the last pixel
        end
    end

    always_ff @(posedge clk_in) begin
        cls_x <= pix_x;
        cls_y <= pix_y;
    end

endmodule

/* logic/seq_divider.sv */
`timescale 1ns/100ps

module seq_divider import tracker_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             start,
    input  logic [SUM_W-1:0] dividend,
    input  logic [SUM_W-1:0] divisor,
    output logic             done,
    output logic [SUM_W-1:0] quotient
);

    logic [SUM_W-1:0]         rem;   // partial remainder
    logic [SUM_W-1:0]         den;
    logic [SUM_W:0]           trial; // remainder shifted with next dividend bit
    logic [$clog2(SUM_W)-1:0] iter;
    logic                     busy;

    // quotient register doubles as the dividend shifter
    assign trial = {rem, quotient[SUM_W-1]};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            done <= 1'b0;
            iter <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (iter == SUM_W - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // SUM_W+1 edges after start
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            rem      <= '0;
            den      <= divisor;
            quotient <= dividend;
        end else if (busy) begin
            if (trial >= {1'b0, den}) begin
                rem      <= SUM_W'(trial - {1'b0, den});  // fits, below den
                quotient <= {quotient[SUM_W-2:0], 1'b1};
            end else begin
                rem      <= trial[SUM_W-1:0];             // restore
                quotient <= {quotient[SUM_W-2:0], 1'b0};
            end
        end
    end

endmodule

/* logic/centroid_accum.sv */
`timescale 1ns/100ps

module centroid_accum import tracker_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               cls_valid,
    input  logic               match,
    input  logic [COORD_W-1:0] cls_x,
    input  logic [COORD_W-1:0] cls_y,
    input  logic               cls_frame_end,
    output logic               cent_valid,
    output logic [COORD_W-1:0] cent_x,
    output logic [COORD_W-1:0] cent_y
);

    logic [SUM_W-1:0]   sum_x, sum_y;
    logic [COUNT_W-1:0] count;
    logic               div_start;
    logic               done_x, done_y;
    logic [SUM_W-1:0]   quo_x, quo_y;

    // dividers sample the sums on the same edge that clears them
    assign div_start = cls_frame_end && (count != '0);  // empty frame, no divide

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (cls_frame_end) begin
            sum_x <= '0;  // fresh frame
            sum_y <= '0;
            count <= '0;
        end else if (cls_valid && match) begin
            sum_x <= sum_x + SUM_W'(cls_x);
            sum_y <= sum_y + SUM_W'(cls_y);
            count <= count + 1'b1;
        end
    end

    seq_divider i_div_x (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (div_start),
        .dividend (sum_x),
        .divisor  (SUM_W'(count)),
        .done     (done_x),
        .quotient (quo_x)
    );

    seq_divider i_div_y (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (div_start),
        .dividend (sum_y),
        .divisor  (SUM_W'(count)),
        .done     (done_y),
        .quotient (quo_y)
    );

    // both finish together, strobe once
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cent_valid <= 1'b0;
        end else begin
            cent_valid <= done_x & done_y;
        end
    end

    always_ff @(posedge clk_in) begin
        if (done_x && done_y) begin
            cent_x <= quo_x[COORD_W-1:0];  // mean never exceeds a coordinate
            cent_y <= quo_y[COORD_W-1:0];
        end
    end

endmodule

/* logic/origin_calibrator.sv */
`timescale 1ns/100ps

module origin_calibrator import tracker_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               frame_end,
    input  logic               head_valid,
    input  logic [COORD_W-1:0] head_x,
    input  logic [COORD_W-1:0] head_y,
    output logic [COORD_W-1:0] origin_x,
    output logic [COORD_W-1:0] origin_y,
    output logic               cal_done
);

    logic [CAL_W-1:0] frames_left;  // settling countdown

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            frames_left <= CAL_W'(CAL_FRAMES);
            cal_done    <= 1'b0;
            origin_x    <= '0;  // zero until calibrated
            origin_y    <= '0;
        end else begin
            if (frame_end && (frames_left != '0)) begin
                frames_left <= frames_left - 1'b1;
            end
            // first head centroid after settling, taken once
            if (head_valid && (frames_left == '0) && !cal_done) begin
                origin_x <= head_x;
                origin_y <= head_y;
                cal_done <= 1'b1;  // sticky until reset
            end
        end
    end

endmodule

/* logic/position_mapper.sv */
`timescale 1ns/100ps

module position_mapper import tracker_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               use_head_offset,
    input  logic               use_hand_offset,
    input  logic               head_cent_valid,
    input  logic [COORD_W-1:0] head_cent_x,
    input  logic [COORD_W-1:0] head_cent_y,
    input  logic               hand_cent_valid,
    input  logic [COORD_W-1:0] hand_cent_x,
    input  logic [COORD_W-1:0] hand_cent_y,
    input  logic [COORD_W-1:0] origin_x,
    input  logic [COORD_W-1:0] origin_y,
    output logic [POS_W-1:0]   head_x,
    output logic [POS_W-1:0]   head_y,
    output logic [POS_W-1:0]   hand_x,
    output logic [POS_W-1:0]   hand_y,
    output logic               head_valid,
    output logic               hand_valid
);

    logic [POS_W-1:0] head_off_x, head_off_y, hand_off_x, hand_off_y;
    logic [POS_W-1:0] head_x_nxt, head_y_nxt, hand_x_nxt, hand_y_nxt;

    // all arithmetic wraps at POS_W
    always_comb begin
        head_off_x = use_head_offset ? POS_W'(origin_x) : '0;
        head_off_y = use_head_offset ? POS_W'(origin_y) : '0;
        hand_off_x = use_hand_offset ? POS_W'(origin_x) : '0;  // hand relative to head origin
        hand_off_y = use_hand_offset ? POS_W'(origin_y) : '0;

        head_x_nxt = POS_W'(head_cent_x) + POS_W'(POS_BIAS) - head_off_x;
        head_y_nxt = POS_W'(head_cent_y) + POS_W'(POS_BIAS) - POS_W'(HEAD_LIFT) - head_off_y;
        hand_x_nxt = POS_W'(hand_cent_x) + POS_W'(POS_BIAS) - hand_off_x;
        hand_y_nxt = POS_W'(hand_cent_y) + POS_W'(POS_BIAS) - hand_off_y;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head_valid <= 1'b0;
            hand_valid <= 1'b0;
        end else begin
            head_valid <= head_cent_valid;
            hand_valid <= hand_cent_valid;
        end
    end

    // positions hold between strobes
    always_ff @(posedge clk_in) begin
        if (head_cent_valid) begin
            head_x <= head_x_nxt;
            head_y <= head_y_nxt;
        end
        if (hand_cent_valid) begin
            hand_x <= hand_x_nxt;
            hand_y <= hand_y_nxt;
        end
    end

endmodule

/* logic/camera_tracker.sv */
`timescale 1ns/100ps

module camera_tracker import tracker_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic [7:0]       cam_data,
    input  logic             cam_pclk,
    input  logic             cam_href,
    input  logic             cam_vsync,
    output logic             cam_xclk,
    output logic             cam_pwdn,
    input  logic             use_hand_offset,
    input  logic             use_head_offset,
    output logic [POS_W-1:0] head_x,
    output logic [POS_W-1:0] head_y,
    output logic             head_valid,
    output logic [POS_W-1:0] hand_x,
    output logic [POS_W-1:0] hand_y,
    output logic             hand_valid,
    output logic             cal_done
);

    // capture side
    logic               pix_valid, frame_end;
    logic [15:0]        pix_rgb;
    logic [COORD_W-1:0] pix_x, pix_y;
    // classified pixels
    logic               cls_valid, is_head, is_hand, cls_frame_end;
    logic [COORD_W-1:0] cls_x, cls_y;
    // centroids and origin
    logic               head_cent_valid, hand_cent_valid;
    logic [COORD_W-1:0] head_cent_x, head_cent_y, hand_cent_x, hand_cent_y;
    logic [COORD_W-1:0] origin_x, origin_y;

    pixel_capture i_pixel_capture (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cam_data  (cam_data),
        .cam_pclk  (cam_pclk),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .cam_xclk  (cam_xclk),
        .cam_pwdn  (cam_pwdn),
        .pix_valid (pix_valid),
        .pix_rgb   (pix_rgb),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .frame_end (frame_end)
    );

    color_classifier i_color_classifier (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .pix_valid     (pix_valid),
        .pix_rgb       (pix_rgb),
        .pix_x         (pix_x),
        .pix_y         (pix_y),
        .frame_end     (frame_end),
        .cls_valid     (cls_valid),
        .cls_x         (cls_x),
        .cls_y         (cls_y),
        .is_head       (is_head),
        .is_hand       (is_hand),
        .cls_frame_end (cls_frame_end)
    );

    // red marker
    centroid_accum i_head_accum (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .cls_valid     (cls_valid),
        .match         (is_head),
        .cls_x         (cls_x),
        .cls_y         (cls_y),
        .cls_frame_end (cls_frame_end),
        .cent_valid    (head_cent_valid),
        .cent_x        (head_cent_x),
        .cent_y        (head_cent_y)
    );

    // blue marker
    centroid_accum i_hand_accum (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .cls_valid     (cls_valid),
        .match         (is_hand),
        .cls_x         (cls_x),
        .cls_y         (cls_y),
        .cls_frame_end (cls_frame_end),
        .cent_valid    (hand_cent_valid),
        .cent_x        (hand_cent_x),
        .cent_y        (hand_cent_y)
    );

    origin_calibrator i_origin_calibrator (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .frame_end  (cls_frame_end),
        .head_valid (head_cent_valid),
        .head_x     (head_cent_x),
        .head_y     (head_cent_y),
        .origin_x   (origin_x),
        .origin_y   (origin_y),
        .cal_done   (cal_done)
    );

    position_mapper i_position_mapper (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .use_head_offset (use_head_offset),
        .use_hand_offset (use_hand_offset),
        .head_cent_valid (head_cent_valid),
        .head_cent_x     (head_cent_x),
        .head_cent_y     (head_cent_y),
        .hand_cent_valid (hand_cent_valid),
        .hand_cent_x     (hand_cent_x),
        .hand_cent_y     (hand_cent_y),
        .origin_x        (origin_x),
        .origin_y        (origin_y),
        .head_x          (head_x),
        .head_y          (head_y),
        .hand_x          (hand_x),
        .hand_y          (hand_y),
        .head_valid      (head_valid),
        .hand_valid      (hand_valid)
    );

endmodule

/* bench/camera_model.sv */
`timescale 1ns/100ps

module camera_model #(
    parameter int FRAME_W    = 64,
    parameter int FRAME_H    = 48,
    parameter int LINE_BLANK = 8,   // pclk periods between lines
    parameter int VSYNC_LEN  = 8    // pclk periods of vsync high and then low
) (
    input  logic       clk_in,
    input  logic       frame_start,
    input  logic [7:0] head_x0, head_y0, head_w, head_h,
    input  logic       hand_on,
    input  logic [7:0] hand_x0, hand_y0, hand_w, hand_h,
    input  logic       noise_on,
    output logic [7:0] cam_data,
    output logic       cam_pclk,
    output logic       cam_href,
    output logic       cam_vsync,
    output logic       frame_busy
);

    function automatic bit inside_rect(input int x, y, x0, y0, w, h);
        return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
    endfunction

    // scene where the first match wins
    function automatic logic [15:0] pixel_color(input int x, input int y);
        if (inside_rect(x, y, head_x0, head_y0, head_w, head_h)) return 16'hf800;  // red
        if (hand_on && inside_rect(x, y, hand_x0, hand_y0, hand_w, hand_h)) return 16'h001f;
        // purple has red and blue both high
        if (noise_on && inside_rect(x, y, 4, 28, 24, 16)) return 16'hf81f;
        // greens that pass the red or blue test and fail only on green
        if (noise_on && inside_rect(x, y, 36, 28, 12, 16)) return 16'ha7e0;  // lime
        if (noise_on && inside_rect(x, y, 48, 28, 12, 16)) return 16'h07f4;  // spring green
        return 16'h0000;  // black background
    endfunction

    // one pclk period is four clk_in cycles and the byte changes while pclk is low
    task automatic pclk_cycle(input logic [7:0] b);
        cam_data <= b;
        cam_pclk <= 1'b0;
        repeat (2) @(posedge clk_in);
        cam_pclk <= 1'b1;
        repeat (2) @(posedge clk_in);
    endtask

    task automatic send_frame();
        logic [15:0] rgb;
        int          x;
        int          y;
        frame_busy <= 1'b1;
        for (y = 0; y < FRAME_H; y++) begin
            cam_href <= 1'b1;
            for (x = 0; x < FRAME_W; x++) begin
                rgb = pixel_color(x, y);
                pclk_cycle(rgb[15:8]);  // r5 g3 first
                pclk_cycle(rgb[7:0]);
            end
            cam_href <= 1'b0;
            repeat (LINE_BLANK) pclk_cycle(8'h00);
        end
        cam_vsync <= 1'b1;  // vsync edge closes the frame
        repeat (VSYNC_LEN) pclk_cycle(8'h00);
        cam_vsync <= 1'b0;
        repeat (VSYNC_LEN) pclk_cycle(8'h00);
        frame_busy <= 1'b0;
    endtask

    initial begin
        cam_data   <= 8'h00;
        cam_pclk   <= 1'b0;
        cam_href   <= 1'b0;
        cam_vsync  <= 1'b0;
        frame_busy <= 1'b0;
        forever begin
            @(posedge clk_in);
            if (frame_start) begin
                send_frame();
            end
        end
    end

endmodule

/* bench/tb_camera_tracker.sv */
`timescale 1ns/100ps

module tb_camera_tracker;

    localparam int     CLK_PERIOD   = 100;
    localparam int     FRAME_W      = 64;
    localparam int     FRAME_H      = 48;
    localparam int     LINE_BLANK   = 8;
    localparam int     VSYNC_LEN    = 8;
    localparam int     NUM_FRAMES   = 9;
    localparam int     FRAME_CYCLES = 4 * (FRAME_H * (2 * FRAME_W + LINE_BLANK) + 2 * VSYNC_LEN);
    localparam longint TIMEOUT_NS   = longint'(NUM_FRAMES) * FRAME_CYCLES * 2 * CLK_PERIOD;
    localparam int     BIAS         = 1800;
    localparam int     LIFT         = 75;   // head y only
    localparam int     SETTLE       = 3;    // frames before the origin is taken

    logic        clk_in, rst_in, use_head_offset, use_hand_offset;
    logic [7:0]  cam_data;
    logic        cam_pclk, cam_href, cam_vsync, cam_xclk, cam_pwdn;
    logic [11:0] head_x, head_y, hand_x, hand_y;
    logic        head_valid, hand_valid, cal_done;
    logic        frame_start, frame_busy, hand_on, noise_on;
    logic [7:0]  head_x0, head_y0, head_w, head_h, hand_x0, hand_y0, hand_w, hand_h;

    logic [31:0] lfsr = 32'hfce3;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          head_seen = 0;   // strobes counted by the monitor
    int          hand_seen = 0;
    int          frames_sent = 0;
    int          hand_total = 0;  // hand strobes expected so far
    bit          vsync_seen = 1'b0;
    string       waiting_for = "reset release";
    // expected outputs of the frame in flight
    int          exp_head_x, exp_head_y, exp_hand_x, exp_hand_y;
    int          origin_x_exp = 0;
    int          origin_y_exp = 0;
    bit          expect_hand, expect_cal;
    bit          calibrated = 1'b0;
    int          err_mark;

    initial clk_in = 1'b0;
    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    camera_model #(
        .FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .LINE_BLANK(LINE_BLANK), .VSYNC_LEN(VSYNC_LEN)
    ) i_camera_model (
        .clk_in(clk_in), .frame_start(frame_start),
        .head_x0(head_x0), .head_y0(head_y0), .head_w(head_w), .head_h(head_h),
        .hand_on(hand_on),
        .hand_x0(hand_x0), .hand_y0(hand_y0), .hand_w(hand_w), .hand_h(hand_h),
        .noise_on(noise_on), .cam_data(cam_data), .cam_pclk(cam_pclk),
        .cam_href(cam_href), .cam_vsync(cam_vsync), .frame_busy(frame_busy)
    );

    camera_tracker i_camera_tracker (
        .clk_in(clk_in), .rst_in(rst_in),
        .cam_data(cam_data), .cam_pclk(cam_pclk), .cam_href(cam_href), .cam_vsync(cam_vsync),
        .cam_xclk(cam_xclk), .cam_pwdn(cam_pwdn),
        .use_hand_offset(use_hand_offset), .use_head_offset(use_head_offset),
        .head_x(head_x), .head_y(head_y), .head_valid(head_valid),
        .hand_x(hand_x), .hand_y(hand_y), .hand_valid(hand_valid), .cal_done(cal_done)
    );

    // galois form stepped once per bit taken
    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // every row has the same mean so one side of the rectangle is enough
    function automatic int rect_mean(input int lo, input int len);
        int sum;
        int i;
        sum = 0;
        for (i = 0; i < len; i++) begin
            sum += lo + i;
        end
        return sum / len;  // floor as all terms are positive
    endfunction

    function automatic int wrap_pos(input int v);
        return v & 32'h0000_0fff;  // modulo 2^12
    endfunction

    task automatic check_value(input string what, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("Error: %0d ns %s is %0d, expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - mark);
        end
    endtask

    // draws the rectangles, sets expectations, sends one frame and waits for its result
    task automatic run_frame(input bit with_hand, input bit with_noise,
                             input bit head_off, input bit hand_off);
        int hx0, hy0, hw, hh, bx0, by0, bw, bh, cx, cy;
        hx0 = rand_bits(4);       // head in the top left quarter
        hw  = rand_bits(4) + 1;
        hy0 = rand_bits(3);
        hh  = rand_bits(4) + 1;
        bx0 = 32 + rand_bits(4);  // hand in the top right quarter
        bw  = rand_bits(4) + 1;
        by0 = rand_bits(3);
        bh  = rand_bits(4) + 1;
        frames_sent++;
        cx = rect_mean(hx0, hw);
        cy = rect_mean(hy0, hh);
        // origin in use is the one from before this frame
        exp_head_x = wrap_pos(cx + BIAS - (head_off ? origin_x_exp : 0));
        exp_head_y = wrap_pos(cy + BIAS - LIFT - (head_off ? origin_y_exp : 0));
        if (with_hand) begin
            exp_hand_x = wrap_pos(rect_mean(bx0, bw) + BIAS - (hand_off ? origin_x_exp : 0));
            exp_hand_y = wrap_pos(rect_mean(by0, bh) + BIAS - (hand_off ? origin_y_exp : 0));
            hand_total++;
        end
        expect_hand = with_hand;
        expect_cal  = !calibrated && (frames_sent >= SETTLE);
        if (expect_cal) begin
            origin_x_exp = cx;
            origin_y_exp = cy;
        end
        @(posedge clk_in);
        head_x0 <= 8'(hx0);
        head_y0 <= 8'(hy0);
        head_w  <= 8'(hw);
        head_h  <= 8'(hh);
        hand_x0 <= 8'(bx0);
        hand_y0 <= 8'(by0);
        hand_w  <= 8'(bw);
        hand_h  <= 8'(bh);
        hand_on <= with_hand;
        noise_on <= with_noise;
        use_head_offset <= head_off;
        use_hand_offset <= hand_off;
        frame_start <= 1'b1;
        @(posedge clk_in);
        frame_start <= 1'b0;
        @(posedge clk_in);  // busy flag visible from here
        waiting_for = "end of the camera frame";
        while (frame_busy) @(posedge clk_in);
        waiting_for = "head_valid strobe";
        while (head_seen < frames_sent) @(posedge clk_in);
        check_value("hand strobe count", hand_seen, hand_total);
    endtask

    // checks every head strobe as hand strobes coincide with it
    always @(posedge clk_in) begin
        if (!rst_in && head_valid) begin
            head_seen <= head_seen + 1;
            check_value("head_x", head_x, exp_head_x);
            check_value("head_y", head_y, exp_head_y);
            check_value("hand_valid", hand_valid, expect_hand);
            check_value("hand_x", hand_x, exp_hand_x);  // held when no blue
            check_value("hand_y", hand_y, exp_hand_y);
            calibrated = calibrated || expect_cal;
            check_value("cal_done", cal_done, calibrated);
            if (calibrated) begin
                check_value("origin_x", i_camera_tracker.origin_x, origin_x_exp);
                check_value("origin_y", i_camera_tracker.origin_y, origin_y_exp);
            end
        end
        if (!rst_in && hand_valid) begin
            hand_seen <= hand_seen + 1;
        end
    end

    always @(posedge clk_in) begin
        if (cam_vsync) begin
            vsync_seen <= 1'b1;  // first frame has ended
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in)
        !vsync_seen |-> !(head_valid || hand_valid || cal_done))
        else begin
            $display("Error: %0d ns output strobe before the first frame ended", $time);
            errors++;
        end
    assert property (@(posedge clk_in) disable iff (rst_in) !cam_pwdn)
        else begin
            $display("Error: %0d ns cam_pwdn is high", $time);
            errors++;
        end
    // master clock flips on every cycle out of reset
    assert property (@(posedge clk_in) disable iff (rst_in)
        !rst_in |=> cam_xclk != $past(cam_xclk))
        else begin
            $display("Error: %0d ns cam_xclk did not toggle", $time);
            errors++;
        end
    assert property (@(posedge clk_in) disable iff (rst_in) head_valid |=> !head_valid)
        else begin
            $display("Error: %0d ns head_valid longer than one cycle", $time);
            errors++;
        end
    assert property (@(posedge clk_in) disable iff (rst_in) hand_valid |-> head_valid)
        else begin
            $display("Error: %0d ns hand_valid without a head strobe", $time);
            errors++;
        end
    assert property (@(posedge clk_in) disable iff (rst_in) $rose(cal_done) |-> head_valid)
        else begin
            $display("Error: %0d ns cal_done rose outside a head strobe", $time);
            errors++;
        end
    assert property (@(posedge clk_in) disable iff (rst_in) cal_done |=> cal_done)
        else begin
            $display("Error: %0d ns cal_done dropped", $time);
            errors++;
        end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog ran out after %0d ns, never got the %s", TIMEOUT_NS, waiting_for);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_in          <= 1'b1;
        use_head_offset <= 1'b0;
        use_hand_offset <= 1'b0;
        frame_start     <= 1'b0;
        hand_on         <= 1'b0;
        noise_on        <= 1'b0;
        {head_x0, head_y0, head_w, head_h} <= '0;
        {hand_x0, hand_y0, hand_w, hand_h} <= '0;
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;

        err_mark = errors;
        run_frame(1'b1, 1'b0, 1'b0, 1'b0);  // quiet until its vsync
        finish_test("reset_quiet", err_mark);

        err_mark = errors;
        run_frame(1'b1, 1'b0, 1'b0, 1'b0);
        finish_test("random_markers", err_mark);

        err_mark = errors;
        run_frame(1'b1, 1'b0, 1'b0, 1'b0);  // third frame takes the origin
        check_value("cal_done after settling", cal_done, 1);
        run_frame(1'b1, 1'b0, 1'b0, 1'b0);
        finish_test("calibration", err_mark);

        err_mark = errors;
        run_frame(1'b0, 1'b0, 1'b0, 1'b0);
        finish_test("no_hand", err_mark);

        err_mark = errors;
        run_frame(1'b1, 1'b0, 1'b1, 1'b1);
        run_frame(1'b1, 1'b0, 1'b1, 1'b0);
        finish_test("offset_modes", err_mark);

        err_mark = errors;
        run_frame(1'b1, 1'b1, 1'b0, 1'b0);  // purple and green patches
        run_frame(1'b1, 1'b1, 1'b1, 1'b1);
        finish_test("off_color", err_mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* camera_tracker.f */
logic/tracker_pkg.sv
logic/pixel_capture.sv
logic/color_classifier.sv
logic/seq_divider.sv
logic/centroid_accum.sv
logic/origin_calibrator.sv
logic/position_mapper.sv
logic/camera_tracker.sv
bench/camera_model.sv
bench/tb_camera_tracker.sv

/* Makefile */
# Verilator build and run for the camera tracker

VERILATOR ?= verilator
TOP       ?= tb_camera_tracker
RTL_TOP   ?= camera_tracker
FILELIST  ?= camera_tracker.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# the log is searched for the pass line, the exit code of tee is not trusted
run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
